// ==== build.f ====
logic/axi_bridge_pkg.sv
logic/beat_counter.sv
logic/read_arbiter.sv
logic/refill_buffer.sv
logic/writeback_ctrl.sv
logic/writeback_buffer.sv
logic/cache_axi_bridge.sv
verification/tb_cache_axi_bridge.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_cache_axi_bridge
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= ALL TESTS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== verification/tb_cache_axi_bridge.sv ====
`timescale 1ns/1ps

module tb_cache_axi_bridge;

    localparam int CLK_PERIOD = 100;
    localparam int NUM_TESTS  = 7;

    typedef enum {K_ICACHE, K_DCACHE, K_UNCACHED, K_WRITE, K_DUAL} kind_e;

    typedef struct {
        string                 name;
        kind_e                 kind;
        axi_bridge_pkg::addr_t addr;
        axi_bridge_pkg::line_t wline;
    } entry_t;

    logic aclk = 1'b0;
    logic rst_n;
    logic icache_rd_req, dcache_rd_req, udcache_rd_req, dcache_wr_req;
    logic icache_rd_rdy, dcache_rd_rdy, udcache_rd_rdy, dcache_wr_rdy;
    logic icache_ret_valid, dcache_ret_valid, udcache_ret_valid;
    axi_bridge_pkg::addr_t    icache_rd_addr, dcache_rd_addr, udcache_rd_addr, dcache_wr_addr;
    axi_bridge_pkg::line_t    icache_ret_data, dcache_ret_data, dcache_wr_data;
    axi_bridge_pkg::word_t    udcache_ret_data;
    logic arvalid, arready, rvalid, rready, rlast;
    logic awvalid, awready, wvalid, wready, wlast, bvalid, bready;
    axi_bridge_pkg::addr_t    araddr, awaddr;
    axi_bridge_pkg::axi_id_t  arid;
    axi_bridge_pkg::axi_len_t arlen;
    axi_bridge_pkg::word_t    rdata, wdata;

    axi_bridge_pkg::word_t    mem [0:63];       // slave memory
    axi_bridge_pkg::word_t    exp_mem [0:63];   // reference copy
    axi_bridge_pkg::axi_id_t  ar_ids [$];
    axi_bridge_pkg::axi_len_t ar_lens [$];
    entry_t tbl [NUM_TESTS];
    string  cur_name = "reset";
    integer seed = 32'h2468_2e21;
    integer rnd;
    int     errors = 0;
    int     w_beats;
    int     r_left = 0;
    int     w_cnt = 0;
    logic [5:0] r_idx = '0;
    logic [5:0] w_base = '0;
    logic [5:0] w_idx;
    logic ar_hs, r_hs, aw_hs, w_hs, b_hs;
    logic b_pend = 1'b0;
    logic exp_last;

    cache_axi_bridge i_dut (.*);

    always #(CLK_PERIOD / 2) aclk = ~aclk;

    task automatic report_mismatch(input string what, input logic [127:0] exp,
                                   input logic [127:0] act);
        $display("mismatch %s (%s): expected %h, actual %h", cur_name, what, exp, act);
        errors++;
    endtask

    task automatic report_failure(input string msg);
        $display("error in %s: %s", cur_name, msg);
        errors++;
    endtask

    function automatic axi_bridge_pkg::line_t expected_line(input axi_bridge_pkg::addr_t addr);
        logic [5:0] base;
        base = {addr[7:4], 2'b00};
        return {exp_mem[base + 6'd3], exp_mem[base + 6'd2], exp_mem[base + 6'd1], exp_mem[base]};
    endfunction

    task automatic check_outputs_idle();
        if ({arvalid, awvalid, wvalid, rready, bready, icache_ret_valid, dcache_ret_valid,
             udcache_ret_valid} !== 8'b0)
            report_failure("bus or return output not low around reset");
    endtask

    // AXI slave samples at the falling edge and drives 5 ns after the rising edge
    always begin
        @(negedge aclk);
        ar_hs = arvalid && arready;
        r_hs  = rvalid && rready;
        aw_hs = awvalid && awready;
        w_hs  = wvalid && wready;
        b_hs  = bvalid && bready;
        if (ar_hs) begin
            ar_ids.push_back(arid);
            ar_lens.push_back(arlen);
            r_idx  = araddr[7:2];
            r_left = int'(arlen) + 1;
        end
        if (r_hs) begin
            r_left = r_left - 1;
            r_idx  = r_idx + 6'd1;
        end
        if (aw_hs) begin
            w_base = awaddr[7:2];
            w_cnt  = 0;
        end
        if (w_hs) begin
            w_idx    = w_base + w_cnt[5:0];
            exp_last = (w_cnt == 3);
            if (wdata !== exp_mem[w_idx])
                report_mismatch("wdata", 128'(exp_mem[w_idx]), 128'(wdata));
            if (wlast !== exp_last)
                report_mismatch("wlast", 128'(exp_last), 128'(wlast));
            mem[w_idx] = wdata;
            w_cnt++;
            w_beats++;
            if (w_cnt == 4) b_pend = 1'b1;
        end
        @(posedge aclk);
        #5;
        rnd     = $random(seed);
        arready = rnd[0];
        awready = rnd[1];
        wready  = rnd[2] | rnd[3];   // mostly ready
        if (!rvalid || r_hs) begin
            rvalid = (r_left > 0) && rnd[4];
            rdata  = mem[r_idx];
            rlast  = rvalid && (r_left == 1);
        end
        if (b_hs) bvalid = 1'b0;
        if (b_pend) begin
            bvalid = 1'b1;
            b_pend = 1'b0;
        end
    end

    task automatic run_reads(input bit want_i, input bit want_d, input bit want_u,
                             input axi_bridge_pkg::addr_t addr);
        bit pend_i, pend_d, pend_u;
        bit drop_i, drop_d, drop_u;
        pend_i = want_i;
        pend_d = want_d;
        pend_u = want_u;
        @(posedge aclk);
        #5;
        icache_rd_addr  = addr;
        dcache_rd_addr  = addr;
        udcache_rd_addr = addr;
        icache_rd_req   = want_i;
        dcache_rd_req   = want_d;
        udcache_rd_req  = want_u;
        while (pend_i || pend_d || pend_u) begin
            @(negedge aclk);
            drop_i = icache_rd_req && icache_rd_rdy;   // taken at the next edge
            drop_d = dcache_rd_req && dcache_rd_rdy;
            drop_u = udcache_rd_req && udcache_rd_rdy;
            if (icache_ret_valid) begin
                if (!pend_i) report_failure("unexpected icache return pulse");
                else if (icache_ret_data !== expected_line(addr))
                    report_mismatch("icache line", expected_line(addr), icache_ret_data);
                pend_i = 0;
            end
            if (dcache_ret_valid) begin
                if (!pend_d) report_failure("unexpected dcache return pulse");
                else if (dcache_ret_data !== expected_line(addr))
                    report_mismatch("dcache line", expected_line(addr), dcache_ret_data);
                pend_d = 0;
            end
            if (udcache_ret_valid) begin
                if (!pend_u) report_failure("unexpected uncached return pulse");
                else if (udcache_ret_data !== exp_mem[addr[7:2]])
                    report_mismatch("uncached word", 128'(exp_mem[addr[7:2]]),
                                    128'(udcache_ret_data));
                pend_u = 0;
            end
            @(posedge aclk);
            #5;
            if (drop_i) icache_rd_req = 1'b0;
            if (drop_d) dcache_rd_req = 1'b0;
            if (drop_u) udcache_rd_req = 1'b0;
        end
        @(negedge aclk);
        if (icache_ret_valid || dcache_ret_valid || udcache_ret_valid)
            report_failure("return pulse longer than one cycle");
        if (ar_ids.size() != int'(want_i) + int'(want_d) + int'(want_u))
            report_failure("wrong number of AR requests");
    endtask

    task automatic run_write(input axi_bridge_pkg::addr_t addr, input axi_bridge_pkg::line_t data);
        logic [5:0] base;
        bit taken;
        base  = {addr[7:4], 2'b00};
        taken = 0;
        for (int i = 0; i < 4; i++) exp_mem[base + i[5:0]] = data[i*32 +: 32];
        @(posedge aclk);
        #5;
        dcache_wr_addr = addr;
        dcache_wr_data = data;
        dcache_wr_req  = 1'b1;
        while (!taken) begin
            @(negedge aclk);
            taken = dcache_wr_rdy;
            @(posedge aclk);
            #5;
        end
        dcache_wr_req = 1'b0;
        @(negedge aclk);
        while (!dcache_wr_rdy) @(negedge aclk);   // back in idle after B
        if (w_beats != 4)
            report_mismatch("write beats", 128'd4, 128'(w_beats));
        for (int i = 0; i < 4; i++) begin
            if (mem[base + i[5:0]] !== data[i*32 +: 32])
                report_mismatch("memory word", 128'(data[i*32 +: 32]), 128'(mem[base + i[5:0]]));
        end
    endtask

    task automatic check_ar(input int pos, input axi_bridge_pkg::axi_id_t id,
                            input axi_bridge_pkg::axi_len_t len);
        if (ar_ids.size() <= pos) begin
            report_failure("AR request missing");
        end else begin
            if (ar_ids[pos] !== id) report_mismatch("arid", 128'(id), 128'(ar_ids[pos]));
            if (ar_lens[pos] !== len) report_mismatch("arlen", 128'(len), 128'(ar_lens[pos]));
        end
    endtask

    initial begin
        #((NUM_TESTS * 200 + 8) * CLK_PERIOD);
        $display("timeout: the bridge stopped responding in %s", cur_name);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        rst_n = 1'b0;
        {icache_rd_req, dcache_rd_req, udcache_rd_req, dcache_wr_req} = 4'b0;
        {icache_rd_addr, dcache_rd_addr, udcache_rd_addr, dcache_wr_addr} = '0;
        dcache_wr_data = '0;
        {arready, rvalid, rlast, awready, wready, bvalid} = 6'b0;
        rdata = '0;
        for (int i = 0; i < 64; i++) begin
            mem[i]     = $random(seed);
            exp_mem[i] = mem[i];
        end
        tbl[0] = '{"icache_refill", K_ICACHE, 32'h0000_004c, '0};
        tbl[1] = '{"dcache_refill", K_DCACHE, 32'h0000_0088, '0};
        tbl[2] = '{"uncached_read", K_UNCACHED, 32'h0000_00c4, '0};
        tbl[3] = '{"writeback", K_WRITE, 32'h0000_0028,
                   128'h1111_0001_2222_0002_3333_0003_4444_0004};
        tbl[4] = '{"refill_after_wb", K_DCACHE, 32'h0000_0024, '0};
        tbl[5] = '{"priority_dual", K_DUAL, 32'h0000_00f0, '0};
        tbl[6] = '{"uncached_after_wb", K_UNCACHED, 32'h0000_002c, '0};

        repeat (8) begin
            @(negedge aclk);
            check_outputs_idle();
        end
        @(posedge aclk);
        #5;
        rst_n = 1'b1;
        @(negedge aclk);
        check_outputs_idle();   // first cycle out of reset

        for (int t = 0; t < NUM_TESTS; t++) begin
            cur_name = tbl[t].name;
            ar_ids.delete();
            ar_lens.delete();
            w_beats = 0;
            case (tbl[t].kind)
                K_ICACHE: begin
                    run_reads(1, 0, 0, tbl[t].addr);
                    check_ar(0, axi_bridge_pkg::ID_ICACHE, axi_bridge_pkg::LEN_LINE);
                end
                K_DCACHE: begin
                    run_reads(0, 1, 0, tbl[t].addr);
                    check_ar(0, axi_bridge_pkg::ID_DCACHE, axi_bridge_pkg::LEN_LINE);
                end
                K_UNCACHED: begin
                    run_reads(0, 0, 1, tbl[t].addr);
                    check_ar(0, axi_bridge_pkg::ID_UNCACHED, axi_bridge_pkg::LEN_WORD);
                end
                K_WRITE: run_write(tbl[t].addr, tbl[t].wline);
                default: begin
                    run_reads(1, 1, 0, tbl[t].addr);   // dcache wins the first grant
                    check_ar(0, axi_bridge_pkg::ID_DCACHE, axi_bridge_pkg::LEN_LINE);
                    check_ar(1, axi_bridge_pkg::ID_ICACHE, axi_bridge_pkg::LEN_LINE);
                end
            endcase
        end

        $display("tests run: %0d, errors: %0d", NUM_TESTS, errors);
        if (errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// ==== logic/cache_axi_bridge.sv ====
`timescale 1ns/1ps

module cache_axi_bridge (
    input  logic                      aclk,
    input  logic                      rst_n,
    // instruction cache refill
    input  logic                      icache_rd_req,
    input  axi_bridge_pkg::addr_t     icache_rd_addr,
    output logic                      icache_rd_rdy,
    output logic                      icache_ret_valid,
    output axi_bridge_pkg::line_t     icache_ret_data,
    // data cache refill and writeback
    input  logic                      dcache_rd_req,
    input  axi_bridge_pkg::addr_t     dcache_rd_addr,
    output logic                      dcache_rd_rdy,
    output logic                      dcache_ret_valid,
    output axi_bridge_pkg::line_t     dcache_ret_data,
    input  logic                      dcache_wr_req,
    input  axi_bridge_pkg::addr_t     dcache_wr_addr,
    input  axi_bridge_pkg::line_t     dcache_wr_data,
    output logic                      dcache_wr_rdy,
    // uncached single word read
    input  logic                      udcache_rd_req,
    input  axi_bridge_pkg::addr_t     udcache_rd_addr,
    output logic                      udcache_rd_rdy,
    output logic                      udcache_ret_valid,
    output axi_bridge_pkg::word_t     udcache_ret_data,
    // AXI read
    output logic                      arvalid,
    input  logic                      arready,
    output axi_bridge_pkg::addr_t     araddr,
    output axi_bridge_pkg::axi_id_t   arid,
    output axi_bridge_pkg::axi_len_t  arlen,
    input  logic                      rvalid,
    output logic                      rready,
    input  axi_bridge_pkg::word_t     rdata,
    input  logic                      rlast,
    // AXI write
    output logic                      awvalid,
    input  logic                      awready,
    output axi_bridge_pkg::addr_t     awaddr,
    output logic                      wvalid,
    input  logic                      wready,
    output axi_bridge_pkg::word_t     wdata,
    output logic                      wlast,
    input  logic                      bvalid,
    output logic                      bready
);

    axi_bridge_pkg::rd_src_e src;
    axi_bridge_pkg::beat_t   rd_count;
    axi_bridge_pkg::beat_t   wr_count;
    axi_bridge_pkg::line_t   rd_line;
    logic                    burst_start;
    logic                    ret_pulse;
    logic                    r_beat;
    logic                    wr_last;
    logic                    wr_load;
    logic                    wr_beat;

    assign r_beat = rvalid && rready;

    // line refills go out aligned, uncached keeps the exact word address
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            araddr <= '0;
        end else if (dcache_rd_req && dcache_rd_rdy) begin
            araddr <= {dcache_rd_addr[31:4], 4'b0000};
        end else if (udcache_rd_req && udcache_rd_rdy) begin
            araddr <= udcache_rd_addr;
        end else if (icache_rd_req && icache_rd_rdy) begin
            araddr <= {icache_rd_addr[31:4], 4'b0000};
        end
    end

    read_arbiter i_rd_arb (
        .aclk           (aclk),
        .rst_n          (rst_n),
        .icache_rd_req  (icache_rd_req),
        .dcache_rd_req  (dcache_rd_req),
        .udcache_rd_req (udcache_rd_req),
        .icache_rd_rdy  (icache_rd_rdy),
        .dcache_rd_rdy  (dcache_rd_rdy),
        .udcache_rd_rdy (udcache_rd_rdy),
        .arvalid        (arvalid),
        .arready        (arready),
        .arid           (arid),
        .arlen          (arlen),
        .rvalid         (rvalid),
        .rlast          (rlast),
        .rready         (rready),
        .src            (src),
        .burst_start    (burst_start),
        .ret_pulse      (ret_pulse)
    );

    // counts R beats to place each one in its line slot
    beat_counter i_rd_beats (
        .aclk  (aclk),
        .rst_n (rst_n),
        .clear (burst_start),
        .beat  (r_beat),
        .count (rd_count),
        .last  ()
    );

    refill_buffer i_refill (
        .aclk              (aclk),
        .rst_n             (rst_n),
        .capture           (r_beat),
        .beat_idx          (rd_count),
        .rdata             (rdata),
        .src               (src),
        .ret_pulse         (ret_pulse),
        .icache_ret_valid  (icache_ret_valid),
        .dcache_ret_valid  (dcache_ret_valid),
        .udcache_ret_valid (udcache_ret_valid),
        .line              (rd_line),
        .word              (udcache_ret_data)
    );

    assign icache_ret_data = rd_line;
    assign dcache_ret_data = rd_line;

    writeback_ctrl i_wb_ctrl (
        .aclk          (aclk),
        .rst_n         (rst_n),
        .dcache_wr_req (dcache_wr_req),
        .dcache_wr_rdy (dcache_wr_rdy),
        .awvalid       (awvalid),
        .awready       (awready),
        .wvalid        (wvalid),
        .wready        (wready),
        .wlast         (wlast),
        .bvalid        (bvalid),
        .bready        (bready),
        .last          (wr_last),
        .load          (wr_load),
        .beat          (wr_beat)
    );

    beat_counter i_wr_beats (
        .aclk  (aclk),
        .rst_n (rst_n),
        .clear (wr_load),
        .beat  (wr_beat),
        .count (wr_count),
        .last  (wr_last)
    );

    writeback_buffer i_wb_buf (
        .aclk           (aclk),
        .rst_n          (rst_n),
        .load           (wr_load),
        .dcache_wr_addr (dcache_wr_addr),
        .dcache_wr_data (dcache_wr_data),
        .beat_idx       (wr_count),
        .awaddr         (awaddr),
        .wdata          (wdata)
    );

endmodule

// ==== logic/writeback_buffer.sv ====
`timescale 1ns/1ps

module writeback_buffer (
    input  logic                   aclk,
    input  logic                   rst_n,
    input  logic                   load,
    input  axi_bridge_pkg::addr_t  dcache_wr_addr,
    input  axi_bridge_pkg::line_t  dcache_wr_data,
    input  axi_bridge_pkg::beat_t  beat_idx,
    output axi_bridge_pkg::addr_t  awaddr,
    output axi_bridge_pkg::word_t  wdata
);

    localparam int WORD_W = $bits(axi_bridge_pkg::word_t);

    axi_bridge_pkg::line_t victim;

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            awaddr <= '0;
        end else if (load) begin
            awaddr <= {dcache_wr_addr[31:4], 4'b0000};   // line aligned
        end
    end

    always_ff @(posedge aclk) begin
        if (load) begin
            victim <= dcache_wr_data;
        end
    end

    // word for the beat currently on W
    assign wdata = victim[beat_idx*WORD_W +: WORD_W];

endmodule

// ==== logic/writeback_ctrl.sv ====
`timescale 1ns/1ps

module writeback_ctrl (
    input  logic  aclk,
    input  logic  rst_n,
    input  logic  dcache_wr_req,
    output logic  dcache_wr_rdy,
    output logic  awvalid,
    input  logic  awready,
    output logic  wvalid,
    input  logic  wready,
    output logic  wlast,
    input  logic  bvalid,
    output logic  bready,
    input  logic  last,     // from the write beat counter
    output logic  load,
    output logic  beat
);

    axi_bridge_pkg::wr_state_e state;
    axi_bridge_pkg::wr_state_e state_nxt;

    assign dcache_wr_rdy = (state == axi_bridge_pkg::WR_IDLE);
    assign awvalid       = (state == axi_bridge_pkg::WR_ADDR);
    assign wvalid        = (state == axi_bridge_pkg::WR_DATA);
    assign bready        = (state == axi_bridge_pkg::WR_RESP);

    assign load  = dcache_wr_req && dcache_wr_rdy;   // victim line accepted
    assign beat  = wvalid && wready;
    assign wlast = wvalid && last;

    always_comb begin
        state_nxt = state;
        case (state)
            axi_bridge_pkg::WR_IDLE: if (load) state_nxt = axi_bridge_pkg::WR_ADDR;
            axi_bridge_pkg::WR_ADDR: if (awready) state_nxt = axi_bridge_pkg::WR_DATA;
            axi_bridge_pkg::WR_DATA: if (beat && last) state_nxt = axi_bridge_pkg::WR_RESP;
            axi_bridge_pkg::WR_RESP: if (bvalid) state_nxt = axi_bridge_pkg::WR_IDLE;
            default:                 state_nxt = axi_bridge_pkg::WR_IDLE;
        endcase
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            state <= axi_bridge_pkg::WR_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // a stalled beat keeps valid and its last flag
    a_wvalid_hold: assert property (@(posedge aclk) disable iff (!rst_n)
        wvalid && !wready |=> wvalid && $stable(wlast));

endmodule

// ==== logic/refill_buffer.sv ====
`timescale 1ns/1ps

module refill_buffer (
    input  logic                     aclk,
    input  logic                     rst_n,
    input  logic                     capture,
    input  axi_bridge_pkg::beat_t    beat_idx,
    input  axi_bridge_pkg::word_t    rdata,
    input  axi_bridge_pkg::rd_src_e  src,
    input  logic                     ret_pulse,
    output logic                     icache_ret_valid,
    output logic                     dcache_ret_valid,
    output logic                     udcache_ret_valid,
    output axi_bridge_pkg::line_t    line,
    output axi_bridge_pkg::word_t    word
);

    localparam int WORD_W = $bits(axi_bridge_pkg::word_t);

    // each taken beat lands in its own slot
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            line <= '0;
        end else if (capture) begin
            line[beat_idx*WORD_W +: WORD_W] <= rdata;
        end
    end

    assign word = line[WORD_W-1:0];   // uncached read uses beat 0 only

    // steer the return pulse to whoever was granted
    assign icache_ret_valid  = ret_pulse && (src == axi_bridge_pkg::SRC_ICACHE);
    assign dcache_ret_valid  = ret_pulse && (src == axi_bridge_pkg::SRC_DCACHE);
    assign udcache_ret_valid = ret_pulse && (src == axi_bridge_pkg::SRC_UNCACHED);

endmodule

// ==== logic/read_arbiter.sv ====
`timescale 1ns/1ps

module read_arbiter (
    input  logic                      aclk,
    input  logic                      rst_n,
    input  logic                      icache_rd_req,
    input  logic                      dcache_rd_req,
    input  logic                      udcache_rd_req,
    output logic                      icache_rd_rdy,
    output logic                      dcache_rd_rdy,
    output logic                      udcache_rd_rdy,
    output logic                      arvalid,
    input  logic                      arready,
    output axi_bridge_pkg::axi_id_t   arid,
    output axi_bridge_pkg::axi_len_t  arlen,
    input  logic                      rvalid,
    input  logic                      rlast,
    output logic                      rready,
    output axi_bridge_pkg::rd_src_e   src,
    output logic                      burst_start,
    output logic                      ret_pulse
);

    axi_bridge_pkg::rd_state_e state;
    axi_bridge_pkg::rd_state_e state_nxt;
    logic                      idle;

    assign idle = (state == axi_bridge_pkg::RD_IDLE);

    // data refill beats uncached, uncached beats instruction refill
    assign dcache_rd_rdy  = idle && dcache_rd_req;
    assign udcache_rd_rdy = idle && udcache_rd_req && !dcache_rd_req;
    assign icache_rd_rdy  = idle && icache_rd_req && !dcache_rd_req && !udcache_rd_req;

    assign burst_start = dcache_rd_rdy || udcache_rd_rdy || icache_rd_rdy;

    assign arvalid   = (state == axi_bridge_pkg::RD_ADDR);
    assign rready    = (state == axi_bridge_pkg::RD_DATA);
    assign ret_pulse = (state == axi_bridge_pkg::RD_RET);

    always_comb begin
        state_nxt = state;
        case (state)
            axi_bridge_pkg::RD_IDLE: if (burst_start) state_nxt = axi_bridge_pkg::RD_ADDR;
            axi_bridge_pkg::RD_ADDR: if (arready) state_nxt = axi_bridge_pkg::RD_DATA;
            axi_bridge_pkg::RD_DATA: if (rvalid && rlast) state_nxt = axi_bridge_pkg::RD_RET;
            default:                 state_nxt = axi_bridge_pkg::RD_IDLE;
        endcase
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            state <= axi_bridge_pkg::RD_IDLE;
            src   <= axi_bridge_pkg::SRC_ICACHE;
        end else begin
            state <= state_nxt;
            if (dcache_rd_rdy)
                src <= axi_bridge_pkg::SRC_DCACHE;
            else if (udcache_rd_rdy)
                src <= axi_bridge_pkg::SRC_UNCACHED;
            else if (icache_rd_rdy)
                src <= axi_bridge_pkg::SRC_ICACHE;
        end
    end

    // id and burst length follow the granted source
    always_comb begin
        case (src)
            axi_bridge_pkg::SRC_DCACHE: begin
                arid  = axi_bridge_pkg::ID_DCACHE;
                arlen = axi_bridge_pkg::LEN_LINE;
            end
            axi_bridge_pkg::SRC_UNCACHED: begin
                arid  = axi_bridge_pkg::ID_UNCACHED;
                arlen = axi_bridge_pkg::LEN_WORD;   // single word
            end
            default: begin
                arid  = axi_bridge_pkg::ID_ICACHE;
                arlen = axi_bridge_pkg::LEN_LINE;
            end
        endcase
    end

    // address request held with a stable id until the slave takes it
    a_arvalid_hold: assert property (@(posedge aclk) disable iff (!rst_n)
        arvalid && !arready |=> arvalid && $stable(arid));

    a_one_grant: assert property (@(posedge aclk) disable iff (!rst_n)
        $onehot0({icache_rd_rdy, dcache_rd_rdy, udcache_rd_rdy}));

endmodule

// ==== logic/beat_counter.sv ====
`timescale 1ns/1ps

module beat_counter (
    input  logic                   aclk,
    input  logic                   rst_n,
    input  logic                   clear,
    input  logic                   beat,
    output axi_bridge_pkg::beat_t  count,
    output logic                   last
);

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (clear) begin   // new burst
            count <= '0;
        end else if (beat) begin
            count <= count + 2'd1;
        end
    end

    assign last = (count == axi_bridge_pkg::beat_t'(axi_bridge_pkg::BEATS_PER_LINE - 1));

    // the channel owner must drop valid once the final beat went through
    a_no_beat_after_last: assert property (@(posedge aclk) disable iff (!rst_n)
        beat && last |=> !beat);

endmodule

// ==== logic/axi_bridge_pkg.sv ====
package axi_bridge_pkg;

    // bus, line and AXI field widths
    typedef logic [31:0]  addr_t;    // byte address
    typedef logic [31:0]  word_t;    // one bus beat
    typedef logic [127:0] line_t;    // one cache line with beat 0 in the low word
    typedef logic [1:0]   beat_t;    // beat index within a line
    typedef logic [3:0]   axi_id_t;
    typedef logic [3:0]   axi_len_t;

    // read ids per requester
    localparam axi_id_t ID_ICACHE   = 4'd0;
    localparam axi_id_t ID_DCACHE   = 4'd1;
    localparam axi_id_t ID_UNCACHED = 4'd2;

    // AXI length field is beats minus one
    localparam axi_len_t LEN_LINE = 4'd3;
    localparam axi_len_t LEN_WORD = 4'd0;

    localparam int BEATS_PER_LINE = 4;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ADDR,   // arvalid up
        RD_DATA,   // rready up
        RD_RET     // one-cycle return pulse
    } rd_state_e;

    typedef enum logic [1:0] {
        SRC_ICACHE,
        SRC_DCACHE,
        SRC_UNCACHED
    } rd_src_e;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_ADDR,   // awvalid up
        WR_DATA,   // wvalid up, four beats
        WR_RESP    // bready up
    } wr_state_e;

endpackage
